/* cpuPkg.sv */
package cpuPkg;

    localparam int wordWidth = 32;
    localparam int regCount = 16;
    localparam int constWidth = 19;
    localparam int shiftBits = $clog2(wordWidth); // Low bits of B used as shift amount.

    typedef logic [wordWidth-1:0] word_t;
    typedef logic [$clog2(regCount)-1:0] regIdx_t;

    // ALU operations, encoded as in the instruction opcode field.
    typedef enum logic [4:0] {
        opAdd = 5'd3,
        opSub = 5'd4,
        opAnd = 5'd5,
        opOr  = 5'd6,
        opShr = 5'd7,
        opShl = 5'd9,
        opMul = 5'd15,
        opDiv = 5'd16,
        opNeg = 5'd17,
        opNot = 5'd18
    } opcode_t;

    // Register-to-register layout.
    typedef struct packed {
        opcode_t opcode;
        regIdx_t ra;
        regIdx_t rb;
        regIdx_t rc;
        logic [14:0] unused;
    } rFormat_t;

    // Immediate layout, constant is sign-extended onto the bus.
    typedef struct packed {
        opcode_t opcode;
        regIdx_t ra;
        regIdx_t rb;
        logic [constWidth-1:0] constant;
    } iFormat_t;

    typedef union packed {
        rFormat_t r;
        iFormat_t i;
        word_t raw;
    } instr_u;

    // One step of strobes from the sequencer.
    typedef struct packed {
        logic gprIn;
        logic pcIn;
        logic irIn;
        logic marIn;
        logic mdrIn;
        logic yIn;
        logic zIn;
        logic hiIn;
        logic loIn;
        logic read;     // MDR takes memory data instead of the bus.
        logic incPc;    // ALU forces B + 1.
        logic gprOut;
        logic pcOut;
        logic mdrOut;
        logic zHighOut;
        logic zLowOut;
        logic hiOut;
        logic loOut;
        logic cOut;
        regIdx_t regSel;
    } ctrl_t;

    typedef struct packed {
        word_t hi;
        word_t lo;
    } hiLo_t;

endpackage

/* regFile.sv */
`timescale 1ns/1ns

module regFile (
    input  logic            clk,
    input  logic            rstN,
    input  logic            writeEn,
    input  cpuPkg::regIdx_t sel,
    input  cpuPkg::word_t   writeData,
    output cpuPkg::word_t   readData
);

    // R0 has no storage.
    cpuPkg::word_t regs [1:cpuPkg::regCount-1];

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            for (int i = 1; i < cpuPkg::regCount; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (writeEn && (sel != '0))
        begin
            regs[sel] <= writeData; // Writes to R0 are dropped.
        end
    end

    // Same index for read and write, as the sequencer names one register per step.
    always_comb
    begin
        if (sel == '0)
        begin
            readData = '0;
        end
        else
        begin
            readData = regs[sel];
        end
    end

endmodule

/* memInterface.sv */
`timescale 1ns/1ns

module memInterface (
    input  logic          clk,
    input  logic          rstN,
    input  cpuPkg::ctrl_t ctrl,
    input  cpuPkg::word_t busData,
    input  cpuPkg::word_t memDataIn,
    output cpuPkg::word_t mdrData,
    output cpuPkg::word_t marAddr
);

    cpuPkg::word_t mdrNext;

    // MDR input mux.
    assign mdrNext = ctrl.read ? memDataIn : busData;

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            marAddr <= '0;
            mdrData <= '0;
        end
        else
        begin
            if (ctrl.marIn)
            begin
                marAddr <= busData; // Address goes straight out to memory.
            end
            if (ctrl.mdrIn)
            begin
                mdrData <= mdrNext;
            end
        end
    end

endmodule

/* alu.sv */
`timescale 1ns/1ns

module alu (
    input  cpuPkg::word_t   opA,
    input  cpuPkg::word_t   opB,
    input  cpuPkg::opcode_t opcode,
    input  logic            incPc,
    output cpuPkg::hiLo_t   result
);

    localparam int w = cpuPkg::wordWidth;

    logic [cpuPkg::shiftBits-1:0] shamt;
    logic signed [2*w-1:0] product;
    logic signed [w:0] dividend;
    logic signed [w:0] divisor;
    logic signed [w:0] quotient;
    logic signed [w:0] remainder;
    logic divByZero;

    assign shamt = opB[cpuPkg::shiftBits-1:0];

    // Both operands signed, so they extend to the full product width.
    assign product = $signed(opA) * $signed(opB);

    // One extra bit keeps the most negative value over minus one from overflowing.
    assign dividend = $signed({opA[w-1], opA});
    assign divisor = $signed({opB[w-1], opB});
    assign divByZero = (opB == '0);

    always_comb
    begin
        if (divByZero)
        begin
            quotient = '0;
            remainder = '0;
        end
        else
        begin
            quotient = dividend / divisor;  // Truncates toward zero.
            remainder = dividend % divisor; // Sign follows the dividend.
        end
    end

    always_comb
    begin
        result = '0;
        if (incPc)
        begin
            result.lo = opB + cpuPkg::word_t'(1); // PC increment ignores the IR.
        end
        else
        begin
            case (opcode)
                cpuPkg::opAdd:
                begin
                    result.lo = opA + opB;
                end
                cpuPkg::opSub:
                begin
                    result.lo = opA - opB;
                end
                cpuPkg::opAnd:
                begin
                    result.lo = opA & opB;
                end
                cpuPkg::opOr:
                begin
                    result.lo = opA | opB;
                end
                cpuPkg::opShl:
                begin
                    result.lo = opA << shamt;
                end
                cpuPkg::opShr:
                begin
                    result.lo = opA >> shamt; // Logical, zero fill.
                end
                cpuPkg::opMul:
                begin
                    result = cpuPkg::hiLo_t'(product);
                end
                cpuPkg::opDiv:
                begin
                    if (divByZero)
                    begin
                        result.lo = '1;
                        result.hi = opA;
                    end
                    else
                    begin
                        result.lo = quotient[w-1:0];
                        result.hi = remainder[w-1:0];
                    end
                end
                // Unary operations act on the bus operand.
                cpuPkg::opNeg:
                begin
                    result.lo = -opB;
                end
                cpuPkg::opNot:
                begin
                    result.lo = ~opB;
                end
                default:
                begin
                    result = '0;
                end
            endcase
        end
    end

endmodule

/* specialRegs.sv */
`timescale 1ns/1ns

module specialRegs (
    input  logic            clk,
    input  logic            rstN,
    input  cpuPkg::ctrl_t   ctrl,
    input  cpuPkg::word_t   busData,
    input  cpuPkg::hiLo_t   aluResult,
    output cpuPkg::word_t   pc,
    output cpuPkg::word_t   y,
    output cpuPkg::hiLo_t   z,
    output cpuPkg::hiLo_t   hiLo,
    output cpuPkg::opcode_t opcode,
    output cpuPkg::word_t   constExt
);

    localparam int extBits = cpuPkg::wordWidth - cpuPkg::constWidth;

    cpuPkg::instr_u ir;

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            pc <= '0;
            ir <= '0;
            y <= '0;
            z <= '0;
            hiLo <= '0;
        end
        else
        begin
            if (ctrl.pcIn)
            begin
                pc <= busData;
            end
            if (ctrl.irIn)
            begin
                ir.raw <= busData;
            end
            if (ctrl.yIn)
            begin
                y <= busData; // Latched A operand for the next ALU step.
            end
            if (ctrl.zIn)
            begin
                z <= aluResult;
            end
            if (ctrl.hiIn)
            begin
                hiLo.hi <= busData;
            end
            if (ctrl.loIn)
            begin
                hiLo.lo <= busData;
            end
        end
    end

    // Opcode sits in the same bits in both layouts.
    assign opcode = ir.r.opcode;

    // I-format view of the same word.
    assign constExt = {{extBits{ir.i.constant[cpuPkg::constWidth-1]}}, ir.i.constant};

endmodule

/* datapath.sv */
`timescale 1ns/1ns

module datapath (
    input  logic          clk,
    input  logic          rstN,
    input  cpuPkg::ctrl_t ctrl,
    input  cpuPkg::word_t memDataIn,
    output cpuPkg::word_t busData,
    output cpuPkg::word_t marAddr,
    output cpuPkg::hiLo_t hiLo
);

    localparam int w = cpuPkg::wordWidth;

    cpuPkg::word_t gprData;
    cpuPkg::word_t mdrData;
    cpuPkg::word_t pc;
    cpuPkg::word_t y;
    cpuPkg::word_t constExt;
    cpuPkg::hiLo_t z;
    cpuPkg::hiLo_t aluResult;
    cpuPkg::opcode_t opcode;

    regFile regFileInst (
        .clk      (clk),
        .rstN     (rstN),
        .writeEn  (ctrl.gprIn),
        .sel      (ctrl.regSel),
        .writeData(busData),
        .readData (gprData)
    );

    memInterface memInst (
        .clk      (clk),
        .rstN     (rstN),
        .ctrl     (ctrl),
        .busData  (busData),
        .memDataIn(memDataIn),
        .mdrData  (mdrData),
        .marAddr  (marAddr)
    );

    specialRegs specialInst (
        .clk      (clk),
        .rstN     (rstN),
        .ctrl     (ctrl),
        .busData  (busData),
        .aluResult(aluResult),
        .pc       (pc),
        .y        (y),
        .z        (z),
        .hiLo     (hiLo),
        .opcode   (opcode),
        .constExt (constExt)
    );

    // Y is always A, the bus is always B.
    alu aluInst (
        .opA   (y),
        .opB   (busData),
        .opcode(opcode),
        .incPc (ctrl.incPc),
        .result(aluResult)
    );

    // AND-OR bus mux. Out-selects are one-hot, so no priority is needed.
    // Idle bus reads zero.
    assign busData = ({w{ctrl.gprOut}}   & gprData)
                   | ({w{ctrl.pcOut}}    & pc)
                   | ({w{ctrl.mdrOut}}   & mdrData)
                   | ({w{ctrl.zHighOut}} & z.hi)
                   | ({w{ctrl.zLowOut}}  & z.lo)
                   | ({w{ctrl.hiOut}}    & hiLo.hi)
                   | ({w{ctrl.loOut}}    & hiLo.lo)
                   | ({w{ctrl.cOut}}     & constExt);

endmodule

/* datapath_asserts.sv */
`timescale 1ns/1ns

module datapath_asserts (
    input logic          clk,
    input logic          rstN,
    input cpuPkg::ctrl_t ctrl,
    input cpuPkg::word_t busData,
    input cpuPkg::word_t marAddr,
    input cpuPkg::word_t gprData,
    input cpuPkg::hiLo_t hiLo
);

    int failCount = 0; // Read by the testbench at the end of the run.
    logic [7:0] outSel;

    assign outSel = {ctrl.gprOut, ctrl.pcOut, ctrl.mdrOut, ctrl.zHighOut,
                     ctrl.zLowOut, ctrl.hiOut, ctrl.loOut, ctrl.cOut};

    // The bus has exactly one driver or none.
    oneBusSource: assert property (@(posedge clk) disable iff (!rstN) $onehot0(outSel))
    else
    begin
        failCount++;
        $error("Several bus sources selected together, %b.", outSel);
    end

    zeroRegister: assert property (@(posedge clk) disable iff (!rstN)
        (ctrl.regSel == '0) |-> (gprData == '0))
    else
    begin
        failCount++;
        $error("R0 read back %h.", gprData);
    end

    // First clock after release.
    cleanAfterReset: assert property (@(posedge clk)
        $rose(rstN) |-> (busData == '0 && marAddr == '0 && hiLo == '0))
    else
    begin
        failCount++;
        $error("Outputs not cleared after reset.");
    end

endmodule

bind datapath datapath_asserts assertsInst (
    .clk    (clk),
    .rstN   (rstN),
    .ctrl   (ctrl),
    .busData(busData),
    .marAddr(marAddr),
    .gprData(gprData),
    .hiLo   (hiLo)
);

/* datapath_tb.sv */
`timescale 1ns/1ns

module datapath_tb;

    localparam int clkPeriod = 40;
    localparam int resetCycles = 8;
    localparam int numPasses = 4;
    localparam logic [31:0] lfsrTaps = 32'h8020_0003;

    typedef enum logic [1:0] {chkNone, chkBus, chkMar, chkHiLo} check_t;

    typedef struct packed {
        cpuPkg::ctrl_t ctrl;
        cpuPkg::word_t memData;
        check_t check;
        cpuPkg::word_t expWord;
        cpuPkg::hiLo_t expHiLo;
    } row_t;

    logic clk = 1'b0;
    logic rstN;
    cpuPkg::ctrl_t ctrl;
    cpuPkg::word_t memDataIn;
    cpuPkg::word_t busData;
    cpuPkg::word_t marAddr;
    cpuPkg::hiLo_t hiLo;

    row_t rows [256];
    int rowCount = 0;
    int rowsPerPass = 0;
    logic [31:0] lfsrState = 32'heb4a_dd4f;

    // Reference model state.
    cpuPkg::word_t mGpr [cpuPkg::regCount];
    cpuPkg::word_t mPc, mMar, mMdr, mY;
    cpuPkg::instr_u mIr;
    cpuPkg::hiLo_t mZ, mHiLo;

    datapath dut_i (.clk(clk), .rstN(rstN), .ctrl(ctrl), .memDataIn(memDataIn),
                    .busData(busData), .marAddr(marAddr), .hiLo(hiLo));

    always #(clkPeriod / 2) clk = ~clk;

    function automatic cpuPkg::word_t nextBits(input int n);
        cpuPkg::word_t value;
        value = '0;
        for (int i = 0; i < n; i++)
        begin
            value = {value[30:0], lfsrState[0]};
            lfsrState = (lfsrState >> 1) ^ (lfsrState[0] ? lfsrTaps : 32'h0);
        end
        return value;
    endfunction

    function automatic cpuPkg::hiLo_t modelAlu(input cpuPkg::word_t a, input cpuPkg::word_t b,
                                               input cpuPkg::opcode_t op, input logic inc);
        cpuPkg::hiLo_t r;
        longint sa;
        longint sb;
        r = '0;
        sa = $signed(a);
        sb = $signed(b);
        if (inc)
            r.lo = b + 32'd1;
        else
            case (op)
                cpuPkg::opAdd: r.lo = a + b;
                cpuPkg::opSub: r.lo = a - b;
                cpuPkg::opAnd: r.lo = a & b;
                cpuPkg::opOr:  r.lo = a | b;
                cpuPkg::opShl: r.lo = a << b[4:0];
                cpuPkg::opShr: r.lo = a >> b[4:0];
                cpuPkg::opMul: r = sa * sb;
                cpuPkg::opDiv: r = (b == '0) ? {a, 32'hffff_ffff}
                                             : {cpuPkg::word_t'(sa % sb), cpuPkg::word_t'(sa / sb)};
                cpuPkg::opNeg: r.lo = -b;
                cpuPkg::opNot: r.lo = ~b;
                default:       r = '0;
            endcase
        return r;
    endfunction

    // Applies one row to the model and returns the bus value of that step.
    function automatic cpuPkg::word_t modelStep(input cpuPkg::ctrl_t c, input cpuPkg::word_t mem);
        cpuPkg::word_t bus;
        int constVal;
        constVal = $signed(mIr.i.constant);
        bus = '0;
        if (c.gprOut) bus |= mGpr[c.regSel];
        if (c.pcOut) bus |= mPc;
        if (c.mdrOut) bus |= mMdr;
        if (c.zHighOut) bus |= mZ.hi;
        if (c.zLowOut) bus |= mZ.lo;
        if (c.hiOut) bus |= mHiLo.hi;
        if (c.loOut) bus |= mHiLo.lo;
        if (c.cOut) bus |= cpuPkg::word_t'(constVal);
        if (c.zIn) mZ = modelAlu(mY, bus, mIr.r.opcode, c.incPc);
        if (c.gprIn && c.regSel != '0) mGpr[c.regSel] = bus;
        if (c.pcIn) mPc = bus;
        if (c.irIn) mIr.raw = bus;
        if (c.marIn) mMar = bus;
        if (c.mdrIn) mMdr = c.read ? mem : bus;
        if (c.yIn) mY = bus;
        if (c.hiIn) mHiLo.hi = bus;
        if (c.loIn) mHiLo.lo = bus;
        return bus;
    endfunction

    task automatic addRow(input cpuPkg::ctrl_t c, input cpuPkg::word_t mem, input check_t chk);
        rows[rowCount] = '{c, mem, chk, '0, '0};
        rowCount++;
    endtask

    function automatic cpuPkg::ctrl_t selectGpr(input cpuPkg::regIdx_t r);
        cpuPkg::ctrl_t c;
        c = '0;
        c.regSel = r;
        return c;
    endfunction

    // Memory word through the MDR, then to the destination named in dest.
    task automatic loadWord(input cpuPkg::ctrl_t dest, input cpuPkg::word_t value);
        cpuPkg::ctrl_t c;
        c = '0;
        c.read = 1'b1;
        c.mdrIn = 1'b1;
        addRow(c, value, chkNone);
        dest.mdrOut = 1'b1;
        addRow(dest, '0, chkNone);
    endtask

    task automatic addFetch();
        cpuPkg::ctrl_t c;
        c = '0;
        c.pcOut = 1'b1;
        c.marIn = 1'b1;
        c.zIn = 1'b1;
        c.incPc = 1'b1;
        addRow(c, '0, chkNone);
        c = '0;
        c.zLowOut = 1'b1;
        c.pcIn = 1'b1;
        addRow(c, '0, chkMar); // MAR holds the old PC here.
        c = '0;
        c.pcOut = 1'b1;
        addRow(c, '0, chkBus);
    endtask

    task automatic addAluTest(input cpuPkg::opcode_t op, input cpuPkg::word_t a,
                              input cpuPkg::word_t b, input logic toHiLo);
        cpuPkg::ctrl_t c;
        cpuPkg::regIdx_t ra;
        cpuPkg::regIdx_t rb;
        cpuPkg::instr_u instr;
        ra = cpuPkg::regIdx_t'(nextBits(4) % 15 + 1);
        rb = cpuPkg::regIdx_t'(ra % 15 + 1); // Never equal to ra, never R0.
        instr.raw = nextBits(32);
        instr.r.opcode = op;
        instr.r.ra = ra;
        instr.r.rb = rb;
        c = selectGpr(ra);
        c.gprIn = 1'b1;
        loadWord(c, a);
        c = selectGpr(rb);
        c.gprIn = 1'b1;
        loadWord(c, b);
        c = '0;
        c.irIn = 1'b1;
        loadWord(c, instr.raw);
        c = selectGpr(ra);
        c.gprOut = 1'b1;
        c.yIn = 1'b1;
        addRow(c, '0, chkNone);
        c = selectGpr(rb);
        c.gprOut = 1'b1;
        c.zIn = 1'b1;
        addRow(c, '0, chkNone);
        c = '0;
        c.zLowOut = 1'b1;
        c.loIn = toHiLo;
        addRow(c, '0, chkBus);
        c = '0;
        c.zHighOut = 1'b1;
        c.hiIn = toHiLo;
        addRow(c, '0, chkBus);
        if (toHiLo)
        begin
            addRow('0, '0, chkHiLo);
            c = '0;
            c.hiOut = 1'b1;
            addRow(c, '0, chkBus);
            c = '0;
            c.loOut = 1'b1;
            addRow(c, '0, chkBus);
        end
    endtask

    task automatic buildPass();
        cpuPkg::ctrl_t c;
        cpuPkg::opcode_t op;
        cpuPkg::regIdx_t r;
        cpuPkg::instr_u instr;
        rowCount = 0;
        addFetch();
        addFetch();
        r = cpuPkg::regIdx_t'(nextBits(4) % 15 + 1);
        c = selectGpr(r);
        c.gprIn = 1'b1;
        loadWord(c, nextBits(32));
        c = selectGpr(r);
        c.gprOut = 1'b1;
        addRow(c, '0, chkBus);
        c = selectGpr('0);
        c.gprIn = 1'b1;
        loadWord(c, nextBits(32));
        c = selectGpr('0);
        c.gprOut = 1'b1;
        addRow(c, '0, chkBus);
        c = selectGpr(r);
        c.gprOut = 1'b1;
        c.mdrIn = 1'b1; // MDR from the bus, read low.
        addRow(c, '0, chkNone);
        c = '0;
        c.mdrOut = 1'b1;
        addRow(c, '0, chkBus);
        op = op.first();
        repeat (op.num())
        begin
            if (op != cpuPkg::opMul && op != cpuPkg::opDiv)
                addAluTest(op, nextBits(32), nextBits(32), 1'b0);
            op = op.next();
        end
        addAluTest(cpuPkg::opMul, nextBits(32), nextBits(32), 1'b1);
        addAluTest(cpuPkg::opDiv, nextBits(32), nextBits(32), 1'b1);
        addAluTest(cpuPkg::opDiv, 32'h144e_a4ea, 32'hffff_ff38, 1'b1);
        addAluTest(cpuPkg::opDiv, nextBits(32), '0, 1'b1);
        instr.raw = nextBits(32);
        instr.i.constant[cpuPkg::constWidth-1] = 1'b1; // Negative constant.
        c = '0;
        c.irIn = 1'b1;
        loadWord(c, instr.raw);
        c = '0;
        c.cOut = 1'b1;
        addRow(c, '0, chkBus);
    endtask

    task automatic fillExpected();
        cpuPkg::word_t bus;
        for (int i = 0; i < rowCount; i++)
        begin
            rows[i].expWord = mMar;
            rows[i].expHiLo = mHiLo;
            bus = modelStep(rows[i].ctrl, rows[i].memData);
            if (rows[i].check == chkBus)
                rows[i].expWord = bus;
        end
    endtask

    task automatic checkWord(input string name, input cpuPkg::word_t actual,
                             input cpuPkg::word_t expected);
        if (actual !== expected)
        begin
            $display("ERR %s actual %h expected %h", name, actual, expected);
            $display("Some tests failed");
            $fatal(1, "Stopped at the first mismatch.");
        end
    endtask

    task automatic checkHiLo(input string name, input cpuPkg::hiLo_t actual,
                             input cpuPkg::hiLo_t expected);
        if (actual !== expected)
        begin
            $display("ERR %s actual %h_%h expected %h_%h", name, actual.hi, actual.lo,
                     expected.hi, expected.lo);
            $display("Some tests failed");
            $fatal(1, "Stopped at the first mismatch.");
        end
    endtask

    task automatic applyTable();
        for (int i = 0; i < rowCount; i++)
        begin
            @(negedge clk);
            ctrl = rows[i].ctrl;
            memDataIn = rows[i].memData;
            #(clkPeriod / 4); // Bus settles well before the next rising edge.
            case (rows[i].check)
                chkBus:  checkWord("busData", busData, rows[i].expWord);
                chkMar:  checkWord("marAddr", marAddr, rows[i].expWord);
                chkHiLo: checkHiLo("hiLo", hiLo, rows[i].expHiLo);
                default:
                begin
                end
            endcase
        end
    endtask

    initial
    begin
        wait (rowsPerPass > 0);
        #((rowsPerPass * numPasses + 20) * clkPeriod);
        $display("Watchdog expired before the stimulus table finished");
        $display("Some tests failed");
        $fatal(1, "Timeout.");
    end

    initial
    begin
        rstN = 1'b0;
        ctrl = '0;
        memDataIn = '0;
        mPc = '0;
        mMar = '0;
        mMdr = '0;
        mY = '0;
        mIr = '0;
        mZ = '0;
        mHiLo = '0;
        for (int i = 0; i < cpuPkg::regCount; i++)
            mGpr[i] = '0;
        repeat (resetCycles) @(negedge clk);
        rstN = 1'b1;
        @(negedge clk);
        #(clkPeriod / 4);
        checkWord("busData", busData, '0);
        checkWord("marAddr", marAddr, '0);
        checkHiLo("hiLo", hiLo, '0);
        for (int pass = 0; pass < numPasses; pass++)
        begin
            buildPass();
            if (pass == 0)
                rowsPerPass = rowCount;
            fillExpected();
            applyTable();
        end
        @(negedge clk);
        ctrl = '0;
        @(negedge clk);
        if (dut_i.assertsInst.failCount != 0)
        begin
            $display("Assertions bound to the datapath reported failures");
            $display("Some tests failed");
            $fatal(1, "Assertion failures.");
        end
        else
        begin
            $display("All tests passed");
            $finish;
        end
    end

endmodule

/* compile.f */
cpuPkg.sv
regFile.sv
memInterface.sv
alu.sv
specialRegs.sv
datapath.sv
datapath_asserts.sv
datapath_tb.sv

/* Bender.yml */
package:
  name: datapath

sources:
  - cpuPkg.sv
  - regFile.sv
  - memInterface.sv
  - alu.sv
  - specialRegs.sv
  - datapath.sv
  - target: test
    files:
      - datapath_asserts.sv
      - datapath_tb.sv
